/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP       ?= tb_fwd_core
FILELIST  ?= fwd_core.f
BUILD_DIR ?= obj_dir
PASS_MSG  := >>> PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* fwd_core.f */
source/isa_pkg.sv
source/pipe_pkg.sv
source/decode_stage.sv
source/exec_pipeline.sv
source/bypass_ctrl.sv
source/reg_file.sv
source/fwd_core_top.sv
tests/fwd_core_chk.sv
tests/tb_fwd_core.sv

/* source/bypass_ctrl.sv */
// Purely combinational; assumes stage flags are set only for records that write a register
`timescale 1ns/1ps

module bypass_ctrl
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      dec_valid_i,
    input  reg_addr_t dec_rs1_i,
    input  reg_addr_t dec_rs2_i,
    input  logic      dec_uses_b_i,
    input  logic      dec_wr_en_i,
    input  reg_addr_t dec_rd_i,
    input  op_class_t dec_class_i,
    input  logic      exe_wr_en_i,
    input  reg_addr_t exe_rd_i,
    input  logic      exe_is_load_i,
    input  word_t     exe_data_i,
    input  logic      m1_wr_en_i,
    input  reg_addr_t m1_rd_i,
    input  logic      m2_wr_en_i,
    input  reg_addr_t m2_rd_i,
    input  logic      m3_wr_en_i,
    input  reg_addr_t m3_rd_i,
    input  logic      m4_wr_en_i,
    input  reg_addr_t m4_rd_i,
    input  logic      m5_wr_en_i,
    input  reg_addr_t m5_rd_i,
    input  word_t     m5_data_i,
    input  logic      tl_wr_en_i,
    input  reg_addr_t tl_rd_i,
    input  logic      c_wr_en_i,
    input  reg_addr_t c_rd_i,
    input  word_t     c_data_i,
    input  logic      wb_wr_en_i,
    input  reg_addr_t wb_rd_i,
    input  word_t     wb_data_i,
    input  logic      cache_hit_i,
    output logic      bypass_a_en_o,
    output logic      bypass_b_en_o,
    output word_t     bypass_data_a_o,
    output word_t     bypass_data_b_o,
    output logic      hazard_stall_o
);

    // Record order is EXE, M1 to M5, TL, C, WB
    localparam int NREC = 9;

    logic [NREC-1:0] rec_en;
    logic [NREC-1:0] rec_ready;
    reg_addr_t       rec_rd   [NREC];
    wb_dist_t        rec_dist [NREC];
    word_t           rec_data [NREC];
    wb_dist_t        own_dist;
    logic            stall_a;
    logic            stall_b;
    logic            struct_hzd;
    logic            waw_hzd;

    always_comb begin
        rec_en = {wb_wr_en_i, c_wr_en_i, tl_wr_en_i, m5_wr_en_i, m4_wr_en_i,
                  m3_wr_en_i, m2_wr_en_i, m1_wr_en_i, exe_wr_en_i};
        rec_ready = {1'b1, cache_hit_i, 1'b0, 1'b1, 4'b0000, !exe_is_load_i};
        rec_rd = '{exe_rd_i, m1_rd_i, m2_rd_i, m3_rd_i, m4_rd_i,
                   m5_rd_i, tl_rd_i, c_rd_i, wb_rd_i};
        rec_data = '{exe_data_i, '0, '0, '0, '0, m5_data_i, '0, c_data_i, wb_data_i};
        rec_dist = '{exe_is_load_i ? LOAD_WB_DIST - 3'd1 : ALU_WB_DIST - 3'd1,
                     MUL_WB_DIST - 3'd1, MUL_WB_DIST - 3'd2, MUL_WB_DIST - 3'd3,
                     MUL_WB_DIST - 3'd4, MUL_WB_DIST - 3'd5,
                     LOAD_WB_DIST - 3'd2, LOAD_WB_DIST - 3'd3, 3'd0};
    end

    // Returns {stall, forward, data} for one source register
    function automatic logic [33:0] resolve(input reg_addr_t src, input logic used);
        logic     found;
        wb_dist_t best;
        int       sel;
        found = 1'b0;
        best  = '0;
        sel   = 0;
        for (int i = 0; i < NREC; i++) begin
            // Largest distance is the youngest writer
            if (used && src != '0 && rec_en[i] && rec_rd[i] == src &&
                (!found || rec_dist[i] > best)) begin
                found = 1'b1;
                best  = rec_dist[i];
                sel   = i;
            end
        end
        if (!found) begin
            return '0;
        end
        if (rec_ready[sel]) begin
            return {2'b01, rec_data[sel]};
        end
        return {2'b10, 32'b0};
    endfunction

    always_comb begin
        {stall_a, bypass_a_en_o, bypass_data_a_o} =
            resolve(dec_rs1_i, dec_valid_i && dec_class_i != CLS_NONE);
        {stall_b, bypass_b_en_o, bypass_data_b_o} =
            resolve(dec_rs2_i, dec_valid_i && dec_uses_b_i);
    end

    always_comb begin
        case (dec_class_i)
            CLS_ALU:  own_dist = ALU_WB_DIST;
            CLS_LOAD: own_dist = LOAD_WB_DIST;
            CLS_MUL:  own_dist = MUL_WB_DIST;
            default:  own_dist = '0;
        endcase
    end

    // Same distance means both reach WB on one edge, a larger one means an older
    // write to our rd would land after ours
    always_comb begin
        struct_hzd = 1'b0;
        waw_hzd    = 1'b0;
        for (int i = 0; i < NREC; i++) begin
            if (dec_valid_i && dec_wr_en_i && rec_en[i]) begin
                if (rec_dist[i] == own_dist) begin
                    struct_hzd = 1'b1;
                end
                if (rec_rd[i] == dec_rd_i && rec_dist[i] > own_dist) begin
                    waw_hzd = 1'b1;
                end
            end
        end
    end

    assign hazard_stall_o = stall_a || stall_b || struct_hzd || waw_hzd;

endmodule

/* source/decode_stage.sv */
// Holds one instruction at a time; the source must keep instr_i steady while stall_o is high
`timescale 1ns/1ps

module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  instr_t    instr_i,
    input  logic      instr_valid_i,
    input  logic      hazard_stall_i,
    input  logic      freeze_i,
    output logic      stall_o,
    output logic      dec_valid_o,
    output reg_addr_t dec_rs1_o,
    output reg_addr_t dec_rs2_o,
    output logic      dec_uses_b_o,
    output reg_addr_t dec_rd_o,
    output logic      dec_wr_en_o,
    output op_class_t dec_class_o,
    output word_t     dec_imm_o,
    output logic      dec_issue_o
);

    instr_t    instr_q;
    logic      valid_q;
    logic      accept;
    op_class_t cls;

    assign stall_o     = valid_q && (hazard_stall_i || freeze_i);
    assign accept      = instr_valid_i && !stall_o;
    assign dec_issue_o = valid_q && !hazard_stall_i && !freeze_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (dec_issue_o) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            instr_q <= instr_i;
        end
    end

    // funct3 must be 000 for ADD, ADDI and MUL and 010 for LW
    always_comb begin
        cls = CLS_NONE;
        case (instr_q[6:0])
            OPC_OP: begin
                if (instr_q[14:12] == 3'b000 && instr_q[31:25] == FUNCT7_MULDIV) begin
                    cls = CLS_MUL;
                end else if (instr_q[14:12] == 3'b000 && instr_q[31:25] == 7'b0) begin
                    cls = CLS_ALU;
                end
            end
            OPC_OP_IMM: cls = (instr_q[14:12] == 3'b000) ? CLS_ALU : CLS_NONE;
            OPC_LOAD:   cls = (instr_q[14:12] == 3'b010) ? CLS_LOAD : CLS_NONE;
            default:    cls = CLS_NONE;
        endcase
    end

    assign dec_valid_o  = valid_q;
    assign dec_class_o  = cls;
    assign dec_uses_b_o = (instr_q[6:0] == OPC_OP) && (cls != CLS_NONE);
    assign dec_rs1_o    = instr_q[19:15];
    assign dec_rd_o     = instr_q[11:7];
    assign dec_wr_en_o  = (cls != CLS_NONE) && (dec_rd_o != '0);

    // I-type reads x0 as rs2 and R-type gets a zero immediate, so EXE can add all three
    assign dec_rs2_o = dec_uses_b_o ? instr_q[24:20] : '0;
    assign dec_imm_o = dec_uses_b_o ? '0 : {{20{instr_q[31]}}, instr_q[31:20]};

endmodule

/* source/exec_pipeline.sv */
// The product is formed whole in M1 and only carried through M2 to M5; a cache miss freezes all
`timescale 1ns/1ps

module exec_pipeline
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      dec_issue_i,
    input  op_class_t dec_class_i,
    input  reg_addr_t dec_rd_i,
    input  logic      dec_wr_en_i,
    input  word_t     dec_imm_i,
    input  word_t     rf_data_a_i,
    input  word_t     rf_data_b_i,
    input  logic      bypass_a_en_i,
    input  logic      bypass_b_en_i,
    input  word_t     bypass_data_a_i,
    input  word_t     bypass_data_b_i,
    input  word_t     cache_data_i,
    input  logic      cache_hit_i,
    output logic      cache_req_o,
    output word_t     cache_addr_o,
    output logic      freeze_o,
    output logic      exe_wr_en_o,
    output reg_addr_t exe_rd_o,
    output logic      exe_is_load_o,
    output word_t     exe_data_o,
    output logic      m1_wr_en_o,
    output reg_addr_t m1_rd_o,
    output logic      m2_wr_en_o,
    output reg_addr_t m2_rd_o,
    output logic      m3_wr_en_o,
    output reg_addr_t m3_rd_o,
    output logic      m4_wr_en_o,
    output reg_addr_t m4_rd_o,
    output logic      m5_wr_en_o,
    output reg_addr_t m5_rd_o,
    output word_t     m5_data_o,
    output logic      tl_wr_en_o,
    output reg_addr_t tl_rd_o,
    output logic      c_wr_en_o,
    output reg_addr_t c_rd_o,
    output word_t     c_data_o,
    output logic      wb_wr_en_o,
    output logic      wb_en_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);

    // EXE and M1 are never filled together, so they share one operand slot
    logic      exe_v_q;
    logic      m1_v_q;
    logic      slot_ld_q;
    logic      slot_wr_q;
    reg_addr_t slot_rd_q;
    word_t     opa_q;
    word_t     opb_q;
    word_t     imm_q;
    logic      m_v_q    [2:5];
    logic      m_wr_q   [2:5];
    reg_addr_t m_rd_q   [2:5];
    word_t     m_data_q [2:5];
    logic      tl_v_q;
    logic      tl_wr_q;
    reg_addr_t tl_rd_q;
    word_t     tl_addr_q;
    logic      c_v_q;
    logic      c_wr_q;
    reg_addr_t c_rd_q;
    word_t     c_addr_q;
    logic      wb_v_q;
    reg_addr_t wb_rd_q;
    word_t     wb_data_q;
    word_t     op_a;
    word_t     op_b;
    word_t     sum;
    logic      take_exe;
    logic      take_mul;
    logic      take_c;

    assign op_a = bypass_a_en_i ? bypass_data_a_i : rf_data_a_i;
    assign op_b = bypass_b_en_i ? bypass_data_b_i : rf_data_b_i;
    assign sum  = opa_q + opb_q + imm_q;

    // At most one of these is set, the bypass controller keeps WB slots apart
    assign take_exe = exe_v_q && !slot_ld_q && slot_wr_q;
    assign take_mul = m_v_q[5] && m_wr_q[5];
    assign take_c   = c_v_q && c_wr_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exe_v_q <= 1'b0;
            m1_v_q  <= 1'b0;
            for (int k = 2; k <= 5; k++) begin
                m_v_q[k] <= 1'b0;
            end
            tl_v_q <= 1'b0;
            c_v_q  <= 1'b0;
            wb_v_q <= 1'b0;
        end else if (!freeze_o) begin
            exe_v_q  <= dec_issue_i && (dec_class_i == CLS_ALU || dec_class_i == CLS_LOAD);
            m1_v_q   <= dec_issue_i && (dec_class_i == CLS_MUL);
            m_v_q[2] <= m1_v_q;
            for (int k = 3; k <= 5; k++) begin
                m_v_q[k] <= m_v_q[k-1];
            end
            tl_v_q <= exe_v_q && slot_ld_q;
            c_v_q  <= tl_v_q;
            wb_v_q <= take_exe || take_mul || take_c;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!freeze_o) begin
            if (dec_issue_i) begin
                slot_ld_q <= (dec_class_i == CLS_LOAD);
                slot_wr_q <= dec_wr_en_i;
                slot_rd_q <= dec_rd_i;
                opa_q     <= op_a;
                opb_q     <= op_b;
                imm_q     <= dec_imm_i;
            end
            m_wr_q[2]   <= slot_wr_q;
            m_rd_q[2]   <= slot_rd_q;
            m_data_q[2] <= opa_q * opb_q;
            for (int k = 3; k <= 5; k++) begin
                m_wr_q[k]   <= m_wr_q[k-1];
                m_rd_q[k]   <= m_rd_q[k-1];
                m_data_q[k] <= m_data_q[k-1];
            end
            tl_wr_q   <= slot_wr_q;
            tl_rd_q   <= slot_rd_q;
            tl_addr_q <= sum;
            c_wr_q    <= tl_wr_q;
            c_rd_q    <= tl_rd_q;
            c_addr_q  <= tl_addr_q;
            if (take_exe) begin
                wb_rd_q   <= slot_rd_q;
                wb_data_q <= sum;
            end else if (take_mul) begin
                wb_rd_q   <= m_rd_q[5];
                wb_data_q <= m_data_q[5];
            end else begin
                wb_rd_q   <= c_rd_q;
                wb_data_q <= cache_data_i;
            end
        end
    end

    assign freeze_o     = c_v_q && !cache_hit_i;
    assign cache_req_o  = c_v_q;
    assign cache_addr_o = c_addr_q;

    assign exe_wr_en_o   = exe_v_q && slot_wr_q;
    assign exe_rd_o      = slot_rd_q;
    assign exe_is_load_o = slot_ld_q;
    assign exe_data_o    = sum;
    assign m1_wr_en_o    = m1_v_q && slot_wr_q;
    assign m1_rd_o       = slot_rd_q;
    assign m2_wr_en_o    = m_v_q[2] && m_wr_q[2];
    assign m2_rd_o       = m_rd_q[2];
    assign m3_wr_en_o    = m_v_q[3] && m_wr_q[3];
    assign m3_rd_o       = m_rd_q[3];
    assign m4_wr_en_o    = m_v_q[4] && m_wr_q[4];
    assign m4_rd_o       = m_rd_q[4];
    assign m5_wr_en_o    = take_mul;
    assign m5_rd_o       = m_rd_q[5];
    assign m5_data_o     = m_data_q[5];
    assign tl_wr_en_o    = tl_v_q && tl_wr_q;
    assign tl_rd_o       = tl_rd_q;
    assign c_wr_en_o     = take_c;
    assign c_rd_o        = c_rd_q;
    assign c_data_o      = cache_data_i;

    // WB holds its record during a freeze, the write strobe waits for the release
    assign wb_wr_en_o = wb_v_q;
    assign wb_en_o    = wb_v_q && !freeze_o;
    assign wb_addr_o  = wb_rd_q;
    assign wb_data_o  = wb_data_q;

endmodule

/* source/fwd_core_top.sv */
// Data cache sits outside; cache_data_i and cache_hit_i must answer in the cycle of the request
`timescale 1ns/1ps

module fwd_core_top
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  instr_t    instr_i,
    input  logic      instr_valid_i,
    output logic      stall_o,
    output logic      cache_req_o,
    output word_t     cache_addr_o,
    input  word_t     cache_data_i,
    input  logic      cache_hit_i,
    output logic      wb_en_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);

    logic      dec_valid, dec_uses_b, dec_wr_en, dec_issue, hazard_stall, freeze;
    reg_addr_t dec_rs1, dec_rs2, dec_rd;
    op_class_t dec_class;
    word_t     dec_imm, rf_data_a, rf_data_b, bypass_data_a, bypass_data_b;
    logic      bypass_a_en, bypass_b_en;
    logic      exe_wr_en, exe_is_load, m1_wr_en, m2_wr_en, m3_wr_en, m4_wr_en, m5_wr_en;
    logic      tl_wr_en, c_wr_en, wb_wr_en;
    reg_addr_t exe_rd, m1_rd, m2_rd, m3_rd, m4_rd, m5_rd, tl_rd, c_rd;
    word_t     exe_data, m5_data, c_data;

    decode_stage decode_i (
        .clk_i, .arst_n_i, .instr_i, .instr_valid_i, .stall_o,
        .hazard_stall_i(hazard_stall), .freeze_i(freeze),
        .dec_valid_o(dec_valid), .dec_rs1_o(dec_rs1), .dec_rs2_o(dec_rs2),
        .dec_uses_b_o(dec_uses_b), .dec_rd_o(dec_rd), .dec_wr_en_o(dec_wr_en),
        .dec_class_o(dec_class), .dec_imm_o(dec_imm), .dec_issue_o(dec_issue)
    );

    exec_pipeline exec_i (
        .clk_i, .arst_n_i, .cache_data_i, .cache_hit_i, .cache_req_o, .cache_addr_o,
        .dec_issue_i(dec_issue), .dec_class_i(dec_class), .dec_rd_i(dec_rd),
        .dec_wr_en_i(dec_wr_en), .dec_imm_i(dec_imm),
        .rf_data_a_i(rf_data_a), .rf_data_b_i(rf_data_b),
        .bypass_a_en_i(bypass_a_en), .bypass_b_en_i(bypass_b_en),
        .bypass_data_a_i(bypass_data_a), .bypass_data_b_i(bypass_data_b),
        .freeze_o(freeze), .exe_wr_en_o(exe_wr_en), .exe_rd_o(exe_rd),
        .exe_is_load_o(exe_is_load), .exe_data_o(exe_data),
        .m1_wr_en_o(m1_wr_en), .m1_rd_o(m1_rd), .m2_wr_en_o(m2_wr_en), .m2_rd_o(m2_rd),
        .m3_wr_en_o(m3_wr_en), .m3_rd_o(m3_rd), .m4_wr_en_o(m4_wr_en), .m4_rd_o(m4_rd),
        .m5_wr_en_o(m5_wr_en), .m5_rd_o(m5_rd), .m5_data_o(m5_data),
        .tl_wr_en_o(tl_wr_en), .tl_rd_o(tl_rd),
        .c_wr_en_o(c_wr_en), .c_rd_o(c_rd), .c_data_o(c_data),
        .wb_wr_en_o(wb_wr_en), .wb_en_o, .wb_addr_o, .wb_data_o
    );

    bypass_ctrl bypass_i (
        .dec_valid_i(dec_valid), .dec_rs1_i(dec_rs1), .dec_rs2_i(dec_rs2),
        .dec_uses_b_i(dec_uses_b), .dec_wr_en_i(dec_wr_en), .dec_rd_i(dec_rd),
        .dec_class_i(dec_class), .exe_wr_en_i(exe_wr_en), .exe_rd_i(exe_rd),
        .exe_is_load_i(exe_is_load), .exe_data_i(exe_data),
        .m1_wr_en_i(m1_wr_en), .m1_rd_i(m1_rd), .m2_wr_en_i(m2_wr_en), .m2_rd_i(m2_rd),
        .m3_wr_en_i(m3_wr_en), .m3_rd_i(m3_rd), .m4_wr_en_i(m4_wr_en), .m4_rd_i(m4_rd),
        .m5_wr_en_i(m5_wr_en), .m5_rd_i(m5_rd), .m5_data_i(m5_data),
        .tl_wr_en_i(tl_wr_en), .tl_rd_i(tl_rd),
        .c_wr_en_i(c_wr_en), .c_rd_i(c_rd), .c_data_i(c_data),
        .wb_wr_en_i(wb_wr_en), .wb_rd_i(wb_addr_o), .wb_data_i(wb_data_o), .cache_hit_i,
        .bypass_a_en_o(bypass_a_en), .bypass_b_en_o(bypass_b_en),
        .bypass_data_a_o(bypass_data_a), .bypass_data_b_o(bypass_data_b),
        .hazard_stall_o(hazard_stall)
    );

    reg_file rf_i (
        .clk_i, .arst_n_i,
        .rd_addr_a_i(dec_rs1), .rd_addr_b_i(dec_rs2),
        .rd_data_a_o(rf_data_a), .rd_data_b_o(rf_data_b),
        .wr_en_i(wb_en_o), .wr_addr_i(wb_addr_o), .wr_data_i(wb_data_o)
    );

endmodule

/* source/isa_pkg.sv */
// RV32 subset only (ADD, ADDI, MUL, LW); every other encoding is treated as a bubble
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;

    // M extension marker in funct7
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

endpackage

/* source/pipe_pkg.sv */
// Distances are tied to the fixed EXE, M1 to M5, TL, C and WB pipeline shape
package pipe_pkg;

    typedef logic [1:0] op_class_t;
    typedef logic [2:0] wb_dist_t;

    localparam op_class_t CLS_NONE = 2'd0;
    localparam op_class_t CLS_ALU  = 2'd1;
    localparam op_class_t CLS_MUL  = 2'd2;
    localparam op_class_t CLS_LOAD = 2'd3;

    // Issue edges until the edge that writes the register file
    localparam wb_dist_t ALU_WB_DIST  = 3'd2;
    localparam wb_dist_t LOAD_WB_DIST = 3'd4;
    localparam wb_dist_t MUL_WB_DIST  = 3'd6;

endpackage

/* source/reg_file.sv */
// Writes land on the clock edge and are not visible to reads in the same cycle
`timescale 1ns/1ps

module reg_file
    import isa_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  reg_addr_t rd_addr_a_i,
    input  reg_addr_t rd_addr_b_i,
    output word_t     rd_data_a_o,
    output word_t     rd_data_b_o,
    input  logic      wr_en_i,
    input  reg_addr_t wr_addr_i,
    input  word_t     wr_data_i
);

    word_t regs [32];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // x0 always reads zero
    assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 : regs[rd_addr_a_i];
    assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 : regs[rd_addr_b_i];

endmodule

/* tests/fwd_core_chk.sv */
// Watches only records that write a register; non-writing bubbles may share a distance
`timescale 1ns/1ps

module fwd_core_chk
    import isa_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      exe_wr_en_i,
    input  logic      exe_is_load_i,
    input  logic      m3_wr_en_i,
    input  logic      m4_wr_en_i,
    input  logic      m5_wr_en_i,
    input  logic      tl_wr_en_i,
    input  logic      c_wr_en_i,
    input  logic      wb_en_i,
    input  reg_addr_t wb_addr_i,
    input  logic      cache_req_i,
    input  logic      cache_hit_i,
    input  logic      tl_busy_i
);

    // Distance 1 is shared by an ALU op in EXE, M5 and C
    a_dist_one: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0({exe_wr_en_i && !exe_is_load_i, m5_wr_en_i, c_wr_en_i}))
        else $error("two writers at distance 1");
    a_dist_two: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(m4_wr_en_i && tl_wr_en_i))
        else $error("two writers at distance 2");
    a_dist_three: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(exe_wr_en_i && exe_is_load_i && m3_wr_en_i))
        else $error("two writers at distance 3");

    a_no_x0: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_en_i |-> wb_addr_i != '0)
        else $error("write-back to x0");

    // A load in C either came from TL or stayed there through a miss
    a_req_load: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        cache_req_i |-> $past(tl_busy_i) || $past(cache_req_i && !cache_hit_i))
        else $error("cache request without a load arriving in C");

endmodule

bind exec_pipeline fwd_core_chk chk_i (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .exe_wr_en_i(exe_wr_en_o), .exe_is_load_i(exe_is_load_o),
    .m3_wr_en_i(m3_wr_en_o), .m4_wr_en_i(m4_wr_en_o), .m5_wr_en_i(m5_wr_en_o),
    .tl_wr_en_i(tl_wr_en_o), .c_wr_en_i(c_wr_en_o),
    .wb_en_i(wb_en_o), .wb_addr_i(wb_addr_o),
    .cache_req_i(cache_req_o), .cache_hit_i(cache_hit_i), .tl_busy_i(tl_v_q)
);

/* tests/tb_fwd_core.sv */
// Cache model answers in the request cycle; misses last as many cycles as address bits 3:2
`timescale 1ns/1ps

module tb_fwd_core
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam word_t CACHE_KEY = 32'h5a5a_c3c3;

    logic      clk_i;
    logic      arst_n_i;
    instr_t    instr_i;
    logic      instr_valid_i;
    logic      stall_o;
    logic      cache_req_o;
    word_t     cache_addr_o;
    word_t     cache_data_i;
    logic      cache_hit_i;
    logic      wb_en_o;
    reg_addr_t wb_addr_o;
    word_t     wb_data_o;

    instr_t      prog [$];
    word_t       exp_q [32][$];
    word_t       model_regs [32];
    int          n_instr;
    int          exp_total;
    int          retired;
    int          cycles;
    int          stall_cycles;
    int          miss_cycles;
    int          pending;
    word_t       req_addr;
    logic        accepted_last;

    fwd_core_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string name);
        if (got !== exp) begin
            report_fail($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            report_fail($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    function automatic instr_t add_op(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, OPC_OP};
    endfunction

    function automatic instr_t mul_op(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
        return {FUNCT7_MULDIV, rs2, rs1, 3'b000, rd, OPC_OP};
    endfunction

    function automatic instr_t addi_op(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OPC_OP_IMM};
    endfunction

    function automatic instr_t lw_op(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, OPC_LOAD};
    endfunction

    // ISA model: returns {writes, value} for one instruction against the model registers
    function automatic logic [32:0] ref_result(instr_t ins);
        word_t a;
        word_t b;
        word_t imm;
        a   = model_regs[ins[19:15]];
        b   = model_regs[ins[24:20]];
        imm = {{20{ins[31]}}, ins[31:20]};
        if (ins[6:0] == OPC_OP && ins[14:12] == 3'b000 && ins[31:25] == 7'b0) begin
            return {1'b1, a + b};
        end else if (ins[6:0] == OPC_OP && ins[14:12] == 3'b000 &&
                     ins[31:25] == FUNCT7_MULDIV) begin
            return {1'b1, a * b};
        end else if (ins[6:0] == OPC_OP_IMM && ins[14:12] == 3'b000) begin
            return {1'b1, a + imm};
        end else if (ins[6:0] == OPC_LOAD && ins[14:12] == 3'b010) begin
            return {1'b1, (a + imm) ^ CACHE_KEY};
        end
        return '0;
    endfunction

    task automatic add_instr(input instr_t ins);
        logic [32:0] res;
        reg_addr_t   rd;
        res = ref_result(ins);
        rd  = ins[11:7];
        prog.push_back(ins);
        n_instr++;
        if (res[32] && rd != '0) begin
            model_regs[rd] = res[31:0];
            exp_q[rd].push_back(res[31:0]);
            exp_total++;
        end
    endtask

    // Feeds the queued program and waits until every expected write has retired
    task automatic run_segment();
        stall_cycles = 0;
        miss_cycles  = 0;
        while (prog.size() > 0 || instr_valid_i || retired < exp_total) begin
            @(negedge clk_i);
        end
    endtask

    // Fetch side and cache model, both on the falling edge
    initial begin
        accepted_last = 1'b0;
        pending       = -1;
        forever begin
            @(negedge clk_i);
            if (arst_n_i) begin
                if (accepted_last) begin
                    instr_valid_i = 1'b0;
                end
                if (!instr_valid_i && prog.size() > 0) begin
                    instr_i       = prog.pop_front();
                    instr_valid_i = 1'b1;
                end
                if (cache_req_o) begin
                    if (pending < 0) begin
                        pending  = {30'b0, cache_addr_o[3:2]};
                        req_addr = cache_addr_o;
                    end else begin
                        check_word(cache_addr_o, req_addr, "cache_addr_o");
                    end
                    cache_data_i = cache_addr_o ^ CACHE_KEY;
                    if (pending == 0) begin
                        cache_hit_i = 1'b1;
                        pending     = -1;
                    end else begin
                        cache_hit_i = 1'b0;
                        pending     = pending - 1;
                        miss_cycles++;
                    end
                end else begin
                    cache_hit_i = 1'b0;
                end
                #1;
                accepted_last = instr_valid_i && !stall_o;
                if (stall_o) begin
                    stall_cycles++;
                end
            end
        end
    end

    // Write-back compare and cycle limit
    initial begin
        word_t ent;
        forever begin
            @(negedge clk_i);
            #2;
            cycles++;
            if (cycles > n_instr * 10 + 100) begin
                report_fail("Timeout: the program did not finish in the cycle limit");
            end
            if (arst_n_i && wb_en_o) begin
                if (exp_q[wb_addr_o].size() == 0) begin
                    report_fail($sformatf("Unexpected write-back to register %0d", wb_addr_o));
                end
                ent = exp_q[wb_addr_o].pop_front();
                check_word(wb_data_o, ent, "wb_data_o");
                retired++;
            end
        end
    end

    initial begin
        reg_addr_t rd;
        reg_addr_t ra;
        reg_addr_t rb;
        int        kind;
        void'($urandom(32'h7afb89a6));
        instr_i       = '0;
        instr_valid_i = 1'b0;
        cache_data_i  = '0;
        cache_hit_i   = 1'b0;
        arst_n_i      = 1'b0;
        n_instr       = 0;
        exp_total     = 0;
        retired       = 0;
        cycles        = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        repeat (3) begin
            @(negedge clk_i);
            #2;
            check_bit(stall_o, 1'b0, "stall_o");
            check_bit(wb_en_o, 1'b0, "wb_en_o");
            check_bit(cache_req_o, 1'b0, "cache_req_o");
        end

        // Back-to-back ALU dependencies are all forwarded
        add_instr(addi_op(5'd1, 5'd0, 12'd5));
        add_instr(addi_op(5'd1, 5'd1, 12'd7));
        add_instr(addi_op(5'd2, 5'd1, 12'hffd));
        add_instr(add_op(5'd3, 5'd1, 5'd2));
        add_instr(add_op(5'd3, 5'd3, 5'd3));
        add_instr(add_op(5'd4, 5'd3, 5'd1));
        run_segment();
        if (stall_cycles != 0) begin
            report_fail("stall_o went high during the dependent ALU chains");
        end

        add_instr(addi_op(5'd5, 5'd0, 12'd12));
        add_instr(mul_op(5'd6, 5'd5, 5'd3));
        add_instr(add_op(5'd7, 5'd6, 5'd5));
        run_segment();
        if (stall_cycles == 0) begin
            report_fail("stall_o never rose for an ADD waiting on a MUL");
        end

        // Offsets pick 3, 1, 2 and 0 miss cycles
        add_instr(lw_op(5'd2, 5'd0, 12'h10c));
        add_instr(add_op(5'd3, 5'd2, 5'd2));
        add_instr(lw_op(5'd4, 5'd0, 12'h104));
        add_instr(lw_op(5'd5, 5'd0, 12'h108));
        add_instr(add_op(5'd6, 5'd4, 5'd5));
        add_instr(lw_op(5'd1, 5'd0, 12'h100));
        run_segment();
        if (miss_cycles == 0) begin
            report_fail("the load sequence saw no cache miss");
        end

        // Write-port collisions and write-after-write on one rd
        add_instr(lw_op(5'd1, 5'd0, 12'h020));
        add_instr(add_op(5'd2, 5'd3, 5'd3));
        add_instr(mul_op(5'd5, 5'd1, 5'd2));
        add_instr(add_op(5'd5, 5'd2, 5'd2));
        add_instr(addi_op(5'd5, 5'd5, 12'd1));
        add_instr(mul_op(5'd6, 5'd6, 5'd6));
        add_instr(lw_op(5'd6, 5'd0, 12'h02c));
        add_instr(add_op(5'd6, 5'd1, 5'd1));
        run_segment();

        for (int n = 0; n < 400; n++) begin
            rd   = reg_addr_t'($urandom_range(7, 0));
            ra   = reg_addr_t'($urandom_range(7, 0));
            rb   = reg_addr_t'($urandom_range(7, 0));
            kind = $urandom_range(4, 0);
            case (kind)
                0: add_instr(add_op(rd, ra, rb));
                1: add_instr(addi_op(rd, ra, 12'($urandom)));
                2: add_instr(mul_op(rd, ra, rb));
                3: add_instr(lw_op(rd, ra, 12'($urandom)));
                default: add_instr({25'($urandom), 7'b0110111});
            endcase
        end
        run_segment();

        // Longest path through the pipeline, so a stray late write still gets counted
        repeat (MUL_WB_DIST + 2) @(negedge clk_i);

        if (retired == exp_total) begin
            $display(">>> PASS");
            $finish;
        end else begin
            report_fail($sformatf("Retired %0d writes but the model expects %0d",
                                  retired, exp_total));
        end
    end

endmodule
